// File: include/tsc_consts.svh
`ifndef TSC_CONSTS_SVH
`define TSC_CONSTS_SVH

// datapath widths
`define TSC_WORD_SIZE 16
`define TSC_NUM_REGS 4

// opcodes, inst[15:12]
`define TSC_OP_RTYPE 4'd15
`define TSC_OP_ADI 4'd4
`define TSC_OP_ORI 4'd5
`define TSC_OP_LHI 4'd6
`define TSC_OP_LWD 4'd7
`define TSC_OP_SWD 4'd8
`define TSC_OP_BNE 4'd0
`define TSC_OP_BEQ 4'd1
`define TSC_OP_JMP 4'd9

// r-type function field, inst[5:0]
`define TSC_FN_ADD 6'd0
`define TSC_FN_SUB 6'd1
`define TSC_FN_AND 6'd2
`define TSC_FN_ORR 6'd3
`define TSC_FN_WWD 6'd28
`define TSC_FN_HLT 6'd29

// alu operation select
`define TSC_ALU_ADD 3'd0
`define TSC_ALU_SUB 3'd1
`define TSC_ALU_AND 3'd2
`define TSC_ALU_ORR 3'd3
`define TSC_ALU_PASSB 3'd4
`define TSC_ALU_PASSA 3'd5

// write-back source select
`define TSC_WB_ALU 2'd0
`define TSC_WB_MEM 2'd1
`define TSC_WB_IMM 2'd2

// first fetch address out of reset
`define TSC_RESET_PC 16'h0000

`endif

// File: rtl/tsc_pkg.sv
`default_nettype none

`include "tsc_consts.svh"

package tsc_pkg;

	// data and address word
	typedef logic [`TSC_WORD_SIZE-1:0] word_t;

	// raw instruction word
	typedef logic [`TSC_WORD_SIZE-1:0] inst_t;

	// index into the register file
	typedef logic [1:0] reg_idx_t;

	// alu operation code, see TSC_ALU_* for the encodings
	typedef logic [2:0] alu_func_t;

	// write-back mux select
	typedef logic [1:0] wb_src_t;

endpackage

`default_nettype wire

// File: rtl/register_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "tsc_consts.svh"

module register_file (
	input  wire                 clk,
	input  wire                 reset,
	input  wire tsc_pkg::reg_idx_t read1,
	input  wire tsc_pkg::reg_idx_t read2,
	input  wire tsc_pkg::reg_idx_t dest,
	input  wire tsc_pkg::word_t write_data,
	input  wire                 reg_write,
	output tsc_pkg::word_t      read_out1,
	output tsc_pkg::word_t      read_out2
);

	tsc_pkg::word_t regs [`TSC_NUM_REGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `TSC_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (reg_write) begin
			regs[dest] <= write_data;
		end
	end

	// write-through so decode sees the value retiring this cycle
	always_comb begin
		if (reg_write && dest == read1) begin
			read_out1 = write_data;
		end else begin
			read_out1 = regs[read1];
		end
		if (reg_write && dest == read2) begin
			read_out2 = write_data;
		end else begin
			read_out2 = regs[read2];
		end
	end

endmodule

`default_nettype wire

// File: rtl/alu.sv
`timescale 1ns/100ps
`default_nettype none

`include "tsc_consts.svh"

module alu (
	input  wire tsc_pkg::word_t     a,
	input  wire tsc_pkg::word_t     b,
	input  wire tsc_pkg::alu_func_t func,
	output tsc_pkg::word_t          result,
	output logic                    equal
);

	always_comb begin
		case (func)
			`TSC_ALU_ADD: begin
				result = a + b;
			end
			`TSC_ALU_SUB: begin
				result = a - b;
			end
			`TSC_ALU_AND: begin
				result = a & b;
			end
			`TSC_ALU_ORR: begin
				result = a | b;
			end
			// lhi carries its immediate through here
			`TSC_ALU_PASSB: begin
				result = b;
			end
			// wwd carries rs down to write-back
			`TSC_ALU_PASSA: begin
				result = a;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	// branch condition, beq and bne both use it
	assign equal = (a == b);

endmodule

`default_nettype wire

// File: rtl/control_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "tsc_consts.svh"

module control_unit (
	input  wire tsc_pkg::inst_t     inst,
	output tsc_pkg::alu_func_t      alu_func,
	output logic                    alu_src_imm,
	output logic                    imm_zero_ext,
	output logic                    reads_rs,
	output logic                    reads_rt,
	output tsc_pkg::reg_idx_t       dest,
	output logic                    reg_write,
	output logic                    mem_read,
	output logic                    mem_write,
	output tsc_pkg::wb_src_t        wb_src,
	output logic                    is_branch,
	output logic                    branch_on_equal,
	output logic                    is_jump,
	output logic                    is_wwd,
	output logic                    is_halt
);

	logic [3:0] opcode;
	logic [5:0] funct;

	assign opcode = inst[15:12];
	assign funct  = inst[5:0];

	always_comb begin
		// defaults describe a bubble
		alu_func        = `TSC_ALU_ADD;
		alu_src_imm     = 1'b0;
		imm_zero_ext    = 1'b0;
		reads_rs        = 1'b0;
		reads_rt        = 1'b0;
		dest            = inst[9:8];
		reg_write       = 1'b0;
		mem_read        = 1'b0;
		mem_write       = 1'b0;
		wb_src          = `TSC_WB_ALU;
		is_branch       = 1'b0;
		branch_on_equal = 1'b0;
		is_jump         = 1'b0;
		is_wwd          = 1'b0;
		is_halt         = 1'b0;

		case (opcode)
			`TSC_OP_RTYPE: begin
				dest = inst[7:6];
				case (funct)
					`TSC_FN_ADD, `TSC_FN_SUB, `TSC_FN_AND, `TSC_FN_ORR: begin
						alu_func  = tsc_pkg::alu_func_t'(funct[1:0]);
						reads_rs  = 1'b1;
						reads_rt  = 1'b1;
						reg_write = 1'b1;
					end
					`TSC_FN_WWD: begin
						alu_func = `TSC_ALU_PASSA;
						reads_rs = 1'b1;
						is_wwd   = 1'b1;
					end
					`TSC_FN_HLT: begin
						is_halt = 1'b1;
					end
					default: begin
					end
				endcase
			end
			`TSC_OP_ADI, `TSC_OP_ORI: begin
				alu_func     = (opcode == `TSC_OP_ORI) ? `TSC_ALU_ORR : `TSC_ALU_ADD;
				imm_zero_ext = (opcode == `TSC_OP_ORI);
				alu_src_imm  = 1'b1;
				reads_rs     = 1'b1;
				reg_write    = 1'b1;
			end
			`TSC_OP_LHI: begin
				alu_func    = `TSC_ALU_PASSB;
				alu_src_imm = 1'b1;
				reg_write   = 1'b1;
				wb_src      = `TSC_WB_IMM;
			end
			// address is rs plus the signed offset
			`TSC_OP_LWD: begin
				alu_src_imm = 1'b1;
				reads_rs    = 1'b1;
				reg_write   = 1'b1;
				mem_read    = 1'b1;
				wb_src      = `TSC_WB_MEM;
			end
			`TSC_OP_SWD: begin
				alu_src_imm = 1'b1;
				reads_rs    = 1'b1;
				reads_rt    = 1'b1;
				mem_write   = 1'b1;
			end
			`TSC_OP_BNE, `TSC_OP_BEQ: begin
				reads_rs        = 1'b1;
				reads_rt        = 1'b1;
				is_branch       = 1'b1;
				branch_on_equal = (opcode == `TSC_OP_BEQ);
			end
			`TSC_OP_JMP: begin
				is_jump = 1'b1;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/hazard_detect.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_detect (
	input  wire tsc_pkg::reg_idx_t rs,
	input  wire tsc_pkg::reg_idx_t rt,
	input  wire                    reads_rs,
	input  wire                    reads_rt,
	input  wire tsc_pkg::reg_idx_t ex_dest,
	input  wire tsc_pkg::reg_idx_t mem_dest,
	input  wire                    ex_reg_write,
	input  wire                    mem_reg_write,
	output logic                   stall
);

	logic rs_hit;
	logic rt_hit;

	// write-back is left out, the register file bypasses it
	assign rs_hit = reads_rs &&
		((ex_reg_write && ex_dest == rs) || (mem_reg_write && mem_dest == rs));
	assign rt_hit = reads_rt &&
		((ex_reg_write && ex_dest == rt) || (mem_reg_write && mem_dest == rt));

	assign stall = rs_hit || rt_hit;

endmodule

`default_nettype wire

// File: rtl/datapath.sv
`timescale 1ns/100ps
`default_nettype none

`include "tsc_consts.svh"

module datapath (
	input  wire                 clk,
	input  wire                 reset,
	output logic                inst_read,
	output tsc_pkg::word_t      inst_addr,
	input  wire tsc_pkg::inst_t inst_data,
	output logic                data_read,
	output logic                data_write,
	output tsc_pkg::word_t      data_addr,
	output tsc_pkg::word_t      data_wdata,
	input  wire tsc_pkg::word_t data_rdata,
	output tsc_pkg::word_t      num_inst,
	output tsc_pkg::word_t      output_port,
	output logic                is_halted
);

	tsc_pkg::word_t pc;
	tsc_pkg::word_t next_pc;

	// fetch/decode
	logic           if_id_valid;
	tsc_pkg::inst_t if_id_inst;
	tsc_pkg::word_t if_id_pc;

	// decode outputs
	tsc_pkg::alu_func_t ctrl_alu_func;
	logic               ctrl_alu_src_imm;
	logic               ctrl_imm_zero_ext;
	logic               ctrl_reads_rs;
	logic               ctrl_reads_rt;
	tsc_pkg::reg_idx_t  ctrl_dest;
	logic               ctrl_reg_write;
	logic               ctrl_mem_read;
	logic               ctrl_mem_write;
	tsc_pkg::wb_src_t   ctrl_wb_src;
	logic               ctrl_is_branch;
	logic               ctrl_branch_on_equal;
	logic               ctrl_is_jump;
	logic               ctrl_is_wwd;
	logic               ctrl_is_halt;
	tsc_pkg::reg_idx_t  id_rs;
	tsc_pkg::reg_idx_t  id_rt;
	tsc_pkg::word_t     id_rs_val;
	tsc_pkg::word_t     id_rt_val;
	tsc_pkg::word_t     id_imm;
	logic               id_valid;
	logic               stall;
	logic               hold_fetch;

	// decode/execute
	logic               id_ex_valid;
	logic               id_ex_reg_write;
	logic               id_ex_mem_read;
	logic               id_ex_mem_write;
	logic               id_ex_is_branch;
	logic               id_ex_is_jump;
	logic               id_ex_is_wwd;
	logic               id_ex_is_halt;
	tsc_pkg::alu_func_t id_ex_alu_func;
	logic               id_ex_alu_src_imm;
	logic               id_ex_branch_on_equal;
	tsc_pkg::reg_idx_t  id_ex_dest;
	tsc_pkg::wb_src_t   id_ex_wb_src;
	tsc_pkg::word_t     id_ex_pc;
	tsc_pkg::word_t     id_ex_rs_val;
	tsc_pkg::word_t     id_ex_rt_val;
	tsc_pkg::word_t     id_ex_imm;
	logic [11:0]        id_ex_jaddr;

	// execute
	tsc_pkg::word_t alu_b;
	tsc_pkg::word_t alu_result;
	logic           alu_equal;
	logic           branch_taken;
	logic           redirect;

	// execute/memory
	logic              ex_mem_valid;
	logic              ex_mem_reg_write;
	logic              ex_mem_mem_read;
	logic              ex_mem_mem_write;
	logic              ex_mem_is_wwd;
	logic              ex_mem_is_halt;
	tsc_pkg::reg_idx_t ex_mem_dest;
	tsc_pkg::wb_src_t  ex_mem_wb_src;
	tsc_pkg::word_t    ex_mem_result;
	tsc_pkg::word_t    ex_mem_store_data;

	// memory/write-back
	logic              mem_wb_valid;
	logic              mem_wb_reg_write;
	logic              mem_wb_is_wwd;
	logic              mem_wb_is_halt;
	tsc_pkg::reg_idx_t mem_wb_dest;
	tsc_pkg::wb_src_t  mem_wb_wb_src;
	tsc_pkg::word_t    mem_wb_result;
	tsc_pkg::word_t    mem_wb_load_data;
	tsc_pkg::word_t    wb_data;

	assign inst_read = ~is_halted;
	assign inst_addr = pc;

	// no fall-through prediction beyond pc+1
	always_comb begin
		if (id_ex_is_jump) begin
			next_pc = {id_ex_pc[15:12], id_ex_jaddr};
		end else if (branch_taken) begin
			next_pc = id_ex_pc + tsc_pkg::word_t'(1) + id_ex_imm;
		end else begin
			next_pc = pc + tsc_pkg::word_t'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= `TSC_RESET_PC;
		end else if (redirect || (!stall && !hold_fetch)) begin
			pc <= next_pc;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || redirect) begin
			if_id_valid <= 1'b0;
		end else if (!stall) begin
			if_id_valid <= ~hold_fetch;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			if_id_inst <= inst_data;
			if_id_pc   <= pc;
		end
	end

	assign id_rs = if_id_inst[11:10];
	assign id_rt = if_id_inst[9:8];

	control_unit u_control (
		.inst            (if_id_inst),
		.alu_func        (ctrl_alu_func),
		.alu_src_imm     (ctrl_alu_src_imm),
		.imm_zero_ext    (ctrl_imm_zero_ext),
		.reads_rs        (ctrl_reads_rs),
		.reads_rt        (ctrl_reads_rt),
		.dest            (ctrl_dest),
		.reg_write       (ctrl_reg_write),
		.mem_read        (ctrl_mem_read),
		.mem_write       (ctrl_mem_write),
		.wb_src          (ctrl_wb_src),
		.is_branch       (ctrl_is_branch),
		.branch_on_equal (ctrl_branch_on_equal),
		.is_jump         (ctrl_is_jump),
		.is_wwd          (ctrl_is_wwd),
		.is_halt         (ctrl_is_halt)
	);

	// unknown encodings set no effect bit and drop out as bubbles
	assign id_valid = if_id_valid & (ctrl_reg_write | ctrl_mem_write | ctrl_is_branch |
		ctrl_is_jump | ctrl_is_wwd | ctrl_is_halt);

	assign id_imm = ctrl_imm_zero_ext ? {8'h00, if_id_inst[7:0]} :
		{{8{if_id_inst[7]}}, if_id_inst[7:0]};

	// stop fetching once a halt is on its way out
	assign hold_fetch = (id_valid & ctrl_is_halt) | id_ex_is_halt | ex_mem_is_halt |
		mem_wb_is_halt | is_halted;

	register_file u_regs (
		.clk        (clk),
		.reset      (reset),
		.read1      (id_rs),
		.read2      (id_rt),
		.dest       (mem_wb_dest),
		.write_data (wb_data),
		.reg_write  (mem_wb_reg_write),
		.read_out1  (id_rs_val),
		.read_out2  (id_rt_val)
	);

	hazard_detect u_hazard (
		.rs            (id_rs),
		.rt            (id_rt),
		.reads_rs      (if_id_valid & ctrl_reads_rs),
		.reads_rt      (if_id_valid & ctrl_reads_rt),
		.ex_dest       (id_ex_dest),
		.mem_dest      (ex_mem_dest),
		.ex_reg_write  (id_ex_reg_write),
		.mem_reg_write (ex_mem_reg_write),
		.stall         (stall)
	);

	// a stalled or flushed slot enters execute as a bubble
	always_ff @(posedge clk) begin
		if (reset || redirect || stall || !id_valid) begin
			id_ex_valid     <= 1'b0;
			id_ex_reg_write <= 1'b0;
			id_ex_mem_read  <= 1'b0;
			id_ex_mem_write <= 1'b0;
			id_ex_is_branch <= 1'b0;
			id_ex_is_jump   <= 1'b0;
			id_ex_is_wwd    <= 1'b0;
			id_ex_is_halt   <= 1'b0;
		end else begin
			id_ex_valid     <= 1'b1;
			id_ex_reg_write <= ctrl_reg_write;
			id_ex_mem_read  <= ctrl_mem_read;
			id_ex_mem_write <= ctrl_mem_write;
			id_ex_is_branch <= ctrl_is_branch;
			id_ex_is_jump   <= ctrl_is_jump;
			id_ex_is_wwd    <= ctrl_is_wwd;
			id_ex_is_halt   <= ctrl_is_halt;
		end
	end

	always_ff @(posedge clk) begin
		id_ex_alu_func        <= ctrl_alu_func;
		id_ex_alu_src_imm     <= ctrl_alu_src_imm;
		id_ex_branch_on_equal <= ctrl_branch_on_equal;
		id_ex_dest            <= ctrl_dest;
		id_ex_wb_src          <= ctrl_wb_src;
		id_ex_pc              <= if_id_pc;
		id_ex_rs_val          <= id_rs_val;
		id_ex_rt_val          <= id_rt_val;
		id_ex_imm             <= id_imm;
		id_ex_jaddr           <= if_id_inst[11:0];
	end

	assign alu_b = id_ex_alu_src_imm ? id_ex_imm : id_ex_rt_val;

	alu u_alu (
		.a      (id_ex_rs_val),
		.b      (alu_b),
		.func   (id_ex_alu_func),
		.result (alu_result),
		.equal  (alu_equal)
	);

	assign branch_taken = id_ex_is_branch & (alu_equal == id_ex_branch_on_equal);
	assign redirect     = branch_taken | id_ex_is_jump;

	always_ff @(posedge clk) begin
		if (reset) begin
			ex_mem_valid     <= 1'b0;
			ex_mem_reg_write <= 1'b0;
			ex_mem_mem_read  <= 1'b0;
			ex_mem_mem_write <= 1'b0;
			ex_mem_is_wwd    <= 1'b0;
			ex_mem_is_halt   <= 1'b0;
		end else begin
			ex_mem_valid     <= id_ex_valid;
			ex_mem_reg_write <= id_ex_reg_write;
			ex_mem_mem_read  <= id_ex_mem_read;
			ex_mem_mem_write <= id_ex_mem_write;
			ex_mem_is_wwd    <= id_ex_is_wwd;
			ex_mem_is_halt   <= id_ex_is_halt;
		end
	end

	always_ff @(posedge clk) begin
		ex_mem_dest       <= id_ex_dest;
		ex_mem_wb_src     <= id_ex_wb_src;
		ex_mem_result     <= alu_result;
		ex_mem_store_data <= id_ex_rt_val;
	end

	// memory answers within the cycle
	assign data_read  = ex_mem_mem_read & ~is_halted;
	assign data_write = ex_mem_mem_write & ~is_halted;
	assign data_addr  = ex_mem_result;
	assign data_wdata = ex_mem_store_data;

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_wb_valid     <= 1'b0;
			mem_wb_reg_write <= 1'b0;
			mem_wb_is_wwd    <= 1'b0;
			mem_wb_is_halt   <= 1'b0;
		end else begin
			mem_wb_valid     <= ex_mem_valid;
			mem_wb_reg_write <= ex_mem_reg_write;
			mem_wb_is_wwd    <= ex_mem_is_wwd;
			mem_wb_is_halt   <= ex_mem_is_halt;
		end
	end

	always_ff @(posedge clk) begin
		mem_wb_dest      <= ex_mem_dest;
		mem_wb_wb_src    <= ex_mem_wb_src;
		mem_wb_result    <= ex_mem_result;
		mem_wb_load_data <= data_rdata;
	end

	// lhi immediate rides in the low byte of the alu result
	always_comb begin
		case (mem_wb_wb_src)
			`TSC_WB_MEM: begin
				wb_data = mem_wb_load_data;
			end
			`TSC_WB_IMM: begin
				wb_data = {mem_wb_result[7:0], 8'h00};
			end
			default: begin
				wb_data = mem_wb_result;
			end
		endcase
	end

	// retirement at the end of write-back
	always_ff @(posedge clk) begin
		if (reset) begin
			num_inst    <= '0;
			output_port <= '0;
			is_halted   <= 1'b0;
		end else begin
			if (mem_wb_valid) begin
				num_inst <= num_inst + tsc_pkg::word_t'(1);
			end
			if (mem_wb_is_wwd) begin
				output_port <= mem_wb_result;
			end
			if (mem_wb_is_halt) begin
				is_halted <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: test/datapath_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module datapath_assertions (
	input wire                 clk,
	input wire                 reset,
	input wire                 inst_read,
	input wire                 data_read,
	input wire                 data_write,
	input wire                 is_halted,
	input wire tsc_pkg::word_t num_inst
);

	// read by the testbench at the end of the run
	int fail_count = 0;

	no_read_and_write: assert property (@(posedge clk) disable iff (reset)
		!(data_read && data_write))
	else begin
		$error("data_read and data_write high together");
		fail_count++;
	end

	// a halted core touches neither port
	quiet_after_halt: assert property (@(posedge clk) disable iff (reset)
		is_halted |-> (!inst_read && !data_read && !data_write))
	else begin
		$error("port strobe while is_halted");
		fail_count++;
	end

	halt_is_sticky: assert property (@(posedge clk) disable iff (reset)
		is_halted |=> is_halted)
	else begin
		$error("is_halted fell without reset");
		fail_count++;
	end

	count_never_drops: assert property (@(posedge clk) disable iff (reset)
		num_inst >= $past(num_inst))
	else begin
		$error("num_inst decreased");
		fail_count++;
	end

endmodule

`default_nettype wire

// File: test/datapath_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "tsc_consts.svh"

module datapath_tb;

	localparam int RESET_CYCLES = 8;
	localparam int MAX_PROG_LEN = 32;
	localparam int RANDOM_PROGS = 3;
	localparam int NUM_PROGS = 4 + RANDOM_PROGS;
	localparam int MEM_WORDS = 1024;
	localparam int MODEL_STEP_LIMIT = 1000;
	localparam int WATCHDOG_CYCLES = NUM_PROGS * (40 * MAX_PROG_LEN + RESET_CYCLES + 20);

	logic           clk;
	logic           reset;
	logic           inst_read;
	tsc_pkg::word_t inst_addr;
	tsc_pkg::inst_t inst_data;
	logic           data_read;
	logic           data_write;
	tsc_pkg::word_t data_addr;
	tsc_pkg::word_t data_wdata;
	tsc_pkg::word_t data_rdata;
	tsc_pkg::word_t num_inst;
	tsc_pkg::word_t output_port;
	logic           is_halted;

	// memory models and the program being run
	tsc_pkg::inst_t imem [MEM_WORDS];
	tsc_pkg::word_t dmem [MEM_WORDS];
	tsc_pkg::inst_t prog [$];

	// expected results from the reference model
	tsc_pkg::word_t model_dmem [MEM_WORDS];
	tsc_pkg::word_t exp_out [$];
	tsc_pkg::word_t exp_waddr [$];
	tsc_pkg::word_t exp_wdata [$];
	tsc_pkg::word_t exp_last_out;
	tsc_pkg::word_t exp_halt_pc;

	int  out_idx = 0;
	int  w_idx = 0;
	bit  monitor_on = 1'b0;
	int  checks = 0;
	int  value_errors = 0;
	int  protocol_errors = 0;
	int  assert_errors = 0;

	datapath dut_i (
		.clk         (clk),
		.reset       (reset),
		.inst_read   (inst_read),
		.inst_addr   (inst_addr),
		.inst_data   (inst_data),
		.data_read   (data_read),
		.data_write  (data_write),
		.data_addr   (data_addr),
		.data_wdata  (data_wdata),
		.data_rdata  (data_rdata),
		.num_inst    (num_inst),
		.output_port (output_port),
		.is_halted   (is_halted)
	);

	bind datapath datapath_assertions assertions_i (
		.clk        (clk),
		.reset      (reset),
		.inst_read  (inst_read),
		.data_read  (data_read),
		.data_write (data_write),
		.is_halted  (is_halted),
		.num_inst   (num_inst)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// both memories answer in the same cycle
	assign inst_data  = imem[inst_addr[9:0]];
	assign data_rdata = dmem[data_addr[9:0]];

	task automatic check_word(input string name, input tsc_pkg::word_t got,
		input tsc_pkg::word_t exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_inst(input string name, input tsc_pkg::inst_t got,
		input tsc_pkg::inst_t exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// store port, every write is compared with the model in order
	always @(posedge clk) begin
		if (data_write) begin
			dmem[data_addr[9:0]] <= data_wdata;
			if (w_idx < exp_waddr.size()) begin
				check_word("data_addr", data_addr, exp_waddr[w_idx]);
				check_word("data_wdata", data_wdata, exp_wdata[w_idx]);
			end else begin
				protocol_errors++;
				$display("unexpected data write to address %h", data_addr);
			end
			w_idx++;
		end
	end

	always @(output_port) begin
		if (monitor_on) begin
			if (out_idx < exp_out.size()) begin
				check_word("output_port", output_port, exp_out[out_idx]);
			end else begin
				protocol_errors++;
				$display("output_port changed to %h after all expected values", output_port);
			end
			out_idx++;
		end
	end

	function automatic tsc_pkg::word_t fill_word(input int idx);
		return tsc_pkg::word_t'(idx * 16'h0409) ^ 16'h5aa5;
	endfunction

	function automatic tsc_pkg::inst_t r_type_word(input logic [1:0] rs, input logic [1:0] rt,
		input logic [1:0] rd, input logic [5:0] fn);
		return {`TSC_OP_RTYPE, rs, rt, rd, fn};
	endfunction

	function automatic tsc_pkg::inst_t imm_word(input logic [3:0] op, input logic [1:0] rs,
		input logic [1:0] rt, input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic tsc_pkg::inst_t jump_word(input logic [11:0] target);
		return {`TSC_OP_JMP, target};
	endfunction

	// instruction-set model, returns the retired count up to the halt
	function automatic int reference_run();
		tsc_pkg::word_t regs [4];
		tsc_pkg::word_t pc;
		tsc_pkg::word_t next_pc;
		tsc_pkg::word_t sext;
		tsc_pkg::word_t zext;
		tsc_pkg::word_t addr;
		tsc_pkg::inst_t inst;
		logic [1:0]     rs;
		logic [1:0]     rt;
		logic [1:0]     rd;
		int             count;
		bit             done;

		for (int i = 0; i < 4; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			model_dmem[i] = fill_word(i);
		end
		exp_out.delete();
		exp_waddr.delete();
		exp_wdata.delete();
		exp_last_out = '0;
		exp_halt_pc = '0;
		pc = `TSC_RESET_PC;
		count = 0;
		done = 1'b0;
		while (!done && count < MODEL_STEP_LIMIT) begin
			inst = imem[pc[9:0]];
			rs = inst[11:10];
			rt = inst[9:8];
			rd = inst[7:6];
			sext = {{8{inst[7]}}, inst[7:0]};
			zext = {8'h00, inst[7:0]};
			addr = regs[rs] + sext;
			next_pc = pc + 16'd1;
			count++;
			case (inst[15:12])
				`TSC_OP_RTYPE: begin
					case (inst[5:0])
						`TSC_FN_ADD: regs[rd] = regs[rs] + regs[rt];
						`TSC_FN_SUB: regs[rd] = regs[rs] - regs[rt];
						`TSC_FN_AND: regs[rd] = regs[rs] & regs[rt];
						`TSC_FN_ORR: regs[rd] = regs[rs] | regs[rt];
						// the port only shows a change of value
						`TSC_FN_WWD: begin
							if (regs[rs] != exp_last_out) begin
								exp_out.push_back(regs[rs]);
							end
							exp_last_out = regs[rs];
						end
						`TSC_FN_HLT: begin
							done = 1'b1;
							exp_halt_pc = pc;
						end
						default: begin
						end
					endcase
				end
				`TSC_OP_ADI: regs[rt] = regs[rs] + sext;
				`TSC_OP_ORI: regs[rt] = regs[rs] | zext;
				`TSC_OP_LHI: regs[rt] = {inst[7:0], 8'h00};
				`TSC_OP_LWD: regs[rt] = model_dmem[addr[9:0]];
				`TSC_OP_SWD: begin
					model_dmem[addr[9:0]] = regs[rt];
					exp_waddr.push_back(addr);
					exp_wdata.push_back(regs[rt]);
				end
				`TSC_OP_BNE: begin
					if (regs[rs] != regs[rt]) begin
						next_pc = pc + 16'd1 + sext;
					end
				end
				`TSC_OP_BEQ: begin
					if (regs[rs] == regs[rt]) begin
						next_pc = pc + 16'd1 + sext;
					end
				end
				`TSC_OP_JMP: next_pc = {pc[15:12], inst[11:0]};
				default: begin
				end
			endcase
			pc = next_pc;
		end
		return count;
	endfunction

	task automatic append_inst(input tsc_pkg::inst_t inst);
		prog.push_back(inst);
	endtask

	task automatic arith_program();
		prog.delete();
		append_inst(imm_word(`TSC_OP_LHI, 2'd0, 2'd1, 8'h12));
		append_inst(imm_word(`TSC_OP_ORI, 2'd1, 2'd1, 8'h34));
		append_inst(imm_word(`TSC_OP_ADI, 2'd0, 2'd2, 8'hfb));
		append_inst(r_type_word(2'd1, 2'd2, 2'd3, `TSC_FN_ADD));
		append_inst(r_type_word(2'd3, 2'd0, 2'd0, `TSC_FN_WWD));
		append_inst(r_type_word(2'd1, 2'd2, 2'd3, `TSC_FN_SUB));
		append_inst(r_type_word(2'd3, 2'd0, 2'd0, `TSC_FN_WWD));
		append_inst(r_type_word(2'd1, 2'd2, 2'd3, `TSC_FN_AND));
		append_inst(r_type_word(2'd3, 2'd0, 2'd0, `TSC_FN_WWD));
		append_inst(r_type_word(2'd2, 2'd1, 2'd3, `TSC_FN_ORR));
		append_inst(r_type_word(2'd3, 2'd0, 2'd0, `TSC_FN_WWD));
		// ori zero-extends, so 0x80 must not set the high byte
		append_inst(imm_word(`TSC_OP_ORI, 2'd0, 2'd2, 8'h80));
		append_inst(r_type_word(2'd2, 2'd0, 2'd0, `TSC_FN_WWD));
		append_inst(imm_word(`TSC_OP_LHI, 2'd0, 2'd0, 8'hff));
		append_inst(r_type_word(2'd0, 2'd0, 2'd0, `TSC_FN_WWD));
		append_inst(r_type_word(2'd0, 2'd0, 2'd0, `TSC_FN_HLT));
	endtask

	task automatic memory_program();
		prog.delete();
		append_inst(imm_word(`TSC_OP_ADI, 2'd0, 2'd1, 8'h10));
		append_inst(imm_word(`TSC_OP_ADI, 2'd0, 2'd2, 8'h55));
		append_inst(imm_word(`TSC_OP_SWD, 2'd1, 2'd2, 8'h00));
		append_inst(imm_word(`TSC_OP_ADI, 2'd2, 2'd2, 8'h01));
		append_inst(imm_word(`TSC_OP_SWD, 2'd1, 2'd2, 8'h01));
		append_inst(imm_word(`TSC_OP_LHI, 2'd0, 2'd3, 8'hab));
		// negative offset
		append_inst(imm_word(`TSC_OP_SWD, 2'd1, 2'd3, 8'hff));
		append_inst(imm_word(`TSC_OP_LWD, 2'd1, 2'd0, 8'h00));
		append_inst(imm_word(`TSC_OP_LWD, 2'd1, 2'd3, 8'h01));
		append_inst(r_type_word(2'd0, 2'd3, 2'd2, `TSC_FN_ADD));
		append_inst(r_type_word(2'd2, 2'd0, 2'd0, `TSC_FN_WWD));
		append_inst(imm_word(`TSC_OP_SWD, 2'd1, 2'd2, 8'h20));
		// untouched word, still holds the fill
		append_inst(imm_word(`TSC_OP_LWD, 2'd1, 2'd0, 8'h05));
		append_inst(r_type_word(2'd0, 2'd0, 2'd0, `TSC_FN_WWD));
		append_inst(r_type_word(2'd0, 2'd0, 2'd0, `TSC_FN_HLT));
	endtask

	task automatic hazard_program();
		prog.delete();
		append_inst(imm_word(`TSC_OP_ADI, 2'd0, 2'd1, 8'h03));
		append_inst(r_type_word(2'd1, 2'd1, 2'd1, `TSC_FN_ADD));
		append_inst(r_type_word(2'd1, 2'd1, 2'd2, `TSC_FN_ADD));
		append_inst(r_type_word(2'd2, 2'd1, 2'd3, `TSC_FN_ADD));
		append_inst(r_type_word(2'd3, 2'd0, 2'd0, `TSC_FN_WWD));
		append_inst(imm_word(`TSC_OP_ADI, 2'd3, 2'd3, 8'h01));
		append_inst(r_type_word(2'd3, 2'd0, 2'd0, `TSC_FN_WWD));
		append_inst(imm_word(`TSC_OP_SWD, 2'd0, 2'd3, 8'h30));
		// load-use right behind the load
		append_inst(imm_word(`TSC_OP_LWD, 2'd0, 2'd2, 8'h30));
		append_inst(r_type_word(2'd2, 2'd2, 2'd2, `TSC_FN_ADD));
		append_inst(r_type_word(2'd2, 2'd0, 2'd0, `TSC_FN_WWD));
		append_inst(r_type_word(2'd0, 2'd0, 2'd0, `TSC_FN_HLT));
	endtask

	// wrong-path slots hold a visible wwd, stores and a halt
	task automatic branch_program();
		prog.delete();
		append_inst(imm_word(`TSC_OP_ADI, 2'd0, 2'd1, 8'h02));
		append_inst(imm_word(`TSC_OP_ADI, 2'd0, 2'd2, 8'h00));
		append_inst(imm_word(`TSC_OP_ADI, 2'd2, 2'd2, 8'h01));
		append_inst(r_type_word(2'd2, 2'd0, 2'd0, `TSC_FN_WWD));
		append_inst(imm_word(`TSC_OP_BNE, 2'd2, 2'd1, 8'hfd));
		append_inst(imm_word(`TSC_OP_BEQ, 2'd2, 2'd1, 8'h02));
		append_inst(r_type_word(2'd0, 2'd0, 2'd0, `TSC_FN_WWD));
		append_inst(imm_word(`TSC_OP_SWD, 2'd0, 2'd1, 8'h40));
		append_inst(imm_word(`TSC_OP_BEQ, 2'd0, 2'd1, 8'h05));
		append_inst(jump_word(12'd12));
		append_inst(r_type_word(2'd0, 2'd0, 2'd0, `TSC_FN_HLT));
		append_inst(imm_word(`TSC_OP_SWD, 2'd0, 2'd0, 8'h41));
		append_inst(imm_word(`TSC_OP_ADI, 2'd0, 2'd3, 8'h77));
		append_inst(r_type_word(2'd3, 2'd0, 2'd0, `TSC_FN_WWD));
		append_inst(r_type_word(2'd0, 2'd0, 2'd0, `TSC_FN_HLT));
	endtask

	task automatic random_program();
		int         len;
		int         kind;
		logic [1:0] a;
		logic [1:0] b;
		logic [1:0] c;
		logic [7:0] imm;

		prog.delete();
		len = 20 + ($urandom % 5);
		for (int i = 0; i < len; i++) begin
			kind = $urandom % 8;
			a = 2'($urandom);
			b = 2'($urandom);
			c = 2'($urandom);
			imm = 8'($urandom);
			case (kind)
				0, 1, 2, 3: append_inst(r_type_word(a, b, c, 6'(kind)));
				4: append_inst(imm_word(`TSC_OP_ADI, a, b, imm));
				5: append_inst(imm_word(`TSC_OP_ORI, a, b, imm));
				6: append_inst(imm_word(`TSC_OP_LHI, 2'd0, b, imm));
				default: append_inst(r_type_word(a, 2'd0, 2'd0, `TSC_FN_WWD));
			endcase
		end
		// dump every register before stopping
		for (int r = 0; r < 4; r++) begin
			append_inst(r_type_word(2'(r), 2'd0, 2'd0, `TSC_FN_WWD));
		end
		append_inst(r_type_word(2'd0, 2'd0, 2'd0, `TSC_FN_HLT));
	endtask

	task automatic execute_program(input string title);
		int             limit;
		int             cycles;
		int             retired;
		tsc_pkg::word_t stop_addr;
		tsc_pkg::inst_t stop_word;

		limit = 40 * prog.size();
		monitor_on = 1'b0;
		@(posedge clk);
		reset <= 1'b1;
		@(posedge clk);
		for (int i = 0; i < MEM_WORDS; i++) begin
			imem[i] = (i < prog.size()) ? prog[i] : r_type_word(2'd0, 2'd0, 2'd0, `TSC_FN_HLT);
			dmem[i] <= fill_word(i);
		end
		retired = reference_run();
		// fetch freezes on the word after the halt
		stop_addr = exp_halt_pc + 16'd1;
		stop_word = (stop_addr < prog.size()) ? prog[stop_addr] :
			r_type_word(2'd0, 2'd0, 2'd0, `TSC_FN_HLT);
		out_idx = 0;
		w_idx = 0;
		repeat (RESET_CYCLES - 1) @(posedge clk);
		reset <= 1'b0;
		monitor_on = 1'b1;

		cycles = 0;
		while (is_halted !== 1'b1 && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (is_halted !== 1'b1) begin
			protocol_errors++;
			$display("program %s did not halt within %0d cycles", title, limit);
		end else begin
			repeat (4) begin
				@(negedge clk);
				if (inst_read !== 1'b0 || data_read !== 1'b0 || data_write !== 1'b0) begin
					protocol_errors++;
					$display("program %s: port strobe active after halt", title);
				end
				check_word("inst_addr", inst_addr, stop_addr);
				check_inst("inst_data", inst_data, stop_word);
			end
			check_word("num_inst", num_inst, tsc_pkg::word_t'(retired));
			check_word("output_port", output_port, exp_last_out);
			if (out_idx != exp_out.size()) begin
				protocol_errors++;
				$display("program %s: saw %0d output values, expected %0d", title, out_idx,
					exp_out.size());
			end
			if (w_idx != exp_waddr.size()) begin
				protocol_errors++;
				$display("program %s: saw %0d data writes, expected %0d", title, w_idx,
					exp_waddr.size());
			end
			for (int i = 0; i < MEM_WORDS; i++) begin
				check_word($sformatf("dmem[%0h]", i), dmem[i], model_dmem[i]);
			end
		end
		monitor_on = 1'b0;
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		$display("Test failed");
		$finish;
	end

	initial begin
		void'($urandom(91));
		reset = 1'b1;
		for (int i = 0; i < MEM_WORDS; i++) begin
			imem[i] = '0;
			dmem[i] <= '0;
		end

		arith_program();
		execute_program("arith");
		memory_program();
		execute_program("memory");
		hazard_program();
		execute_program("hazard");
		branch_program();
		execute_program("branch");
		for (int r = 0; r < RANDOM_PROGS; r++) begin
			random_program();
			execute_program($sformatf("random %0d", r));
		end

		assert_errors = dut_i.assertions_i.fail_count;
		$display("checks %0d, value errors %0d, protocol errors %0d, assertion errors %0d",
			checks, value_errors, protocol_errors, assert_errors);
		if (value_errors == 0 && protocol_errors == 0 && assert_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
rtl/tsc_pkg.sv
rtl/register_file.sv
rtl/alu.sv
rtl/control_unit.sv
rtl/hazard_detect.sv
rtl/datapath.sv
test/datapath_assertions.sv
test/datapath_tb.sv

// File: Bender.yml
package:
  name: tsc_core

export_include_dirs:
  - include

sources:
  - rtl/tsc_pkg.sv
  - rtl/register_file.sv
  - rtl/alu.sv
  - rtl/control_unit.sv
  - rtl/hazard_detect.sv
  - rtl/datapath.sv
  - target: test
    files:
      - test/datapath_assertions.sv
      - test/datapath_tb.sv
